//--- axw_pkg.sv
// Bus widths, burst constants and packed structs for the AXI stream write master
`default_nettype none

package axw_pkg;

  //////////////////////////////
  // Bus widths
  //////////////////////////////
  localparam int DATA_W     = 32;
  localparam int ADDR_W     = 32;
  // Size field of a command in bytes
  localparam int XFER_W     = 16;
  localparam int BEAT_BYTES = DATA_W / 8;

  //////////////////////////////
  // Burst geometry
  //////////////////////////////
  // A burst may not cross 4 KB and may not exceed 256 beats
  localparam int BURST_BEATS = (4096 / BEAT_BYTES < 256) ? 4096 / BEAT_BYTES : 256;
  localparam int BURST_BYTES = BEAT_BYTES * BURST_BEATS;
  // Beat count minus one within a burst
  localparam int LEN_W       = $clog2(BURST_BEATS);
  // Full-burst count taken from the upper bits of the beat count
  localparam int TXN_W       = XFER_W - $clog2(BEAT_BYTES) - LEN_W;

  // Command as sampled on ctrl_start
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [XFER_W-1:0] size;
  } cmd_t;

  // Decoded transfer
  typedef struct packed {
    logic [ADDR_W-1:0]     base;       // Burst aligned start
    logic [TXN_W-1:0]      txn_m1;     // Bursts minus one
    logic [LEN_W-1:0]      last_len;   // Final burst beats minus one
    logic [BEAT_BYTES-1:0] last_strb;  // Lanes of the final beat
  } plan_t;

  // AW payload
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } aw_beat_t;

  // W payload
  typedef struct packed {
    logic [DATA_W-1:0]     data;
    logic [BEAT_BYTES-1:0] strb;
    logic                  last;
  } w_beat_t;

endpackage

`default_nettype wire

//--- axw_counter.sv
// Loadable up/down counter with a type-parameterized count and zero flag
`timescale 1ns/1ps
`default_nettype none

module axw_counter #(
  parameter type    count_t = logic [7:0],
  parameter count_t INIT    = '0
) (
  input  wire         aclk,
  input  wire         areset,
  input  wire         load,
  input  wire count_t load_value,
  input  wire         incr,
  input  wire         decr,
  output count_t      count,
  output logic        is_zero
);

  //////////////////////////////
  // Count register
  //////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      count <= INIT;
    end else if (load) begin
      // Load wins over any step
      count <= load_value;
    end else if (incr && !decr) begin
      count <= count + 1'b1;
    end else if (decr && !incr) begin
      count <= count - 1'b1;
    end
    // Both steps at once leave the count unchanged
  end

  // Zero flag straight from the register
  assign is_zero = (count == '0);

endmodule

`default_nettype wire

//--- axw_cmd_decode.sv
// Command register, burst plan arithmetic and final-beat strobe generation
`timescale 1ns/1ps
`default_nettype none

module axw_cmd_decode (
  input  wire                 aclk,
  input  wire                 ctrl_start,
  input  wire axw_pkg::cmd_t  ctrl_cmd,
  output axw_pkg::plan_t      plan,
  output logic                plan_load
);

  localparam int BEAT_SHIFT = $clog2(axw_pkg::BEAT_BYTES);
  localparam int BEATS_W    = axw_pkg::XFER_W - BEAT_SHIFT;
  // Low address bits below a burst boundary
  localparam logic [axw_pkg::ADDR_W-1:0] ADDR_MASK =
    axw_pkg::ADDR_W'(axw_pkg::BURST_BYTES - 1);

  axw_pkg::cmd_t                 cmd_r;
  logic                          start_d1;
  logic [BEAT_SHIFT-1:0]         size_rem;
  logic [BEATS_W-1:0]            size_hi;
  logic [BEATS_W-1:0]            beats_m1;
  logic [axw_pkg::BEAT_BYTES-1:0] strb;

  //////////////////////////////
  // Stage 1 command capture
  //////////////////////////////
  always_ff @(posedge aclk) begin
    start_d1 <= ctrl_start;
    if (ctrl_start) begin
      cmd_r <= ctrl_cmd;
    end
  end

  // Bytes beyond the last whole beat
  assign size_rem = cmd_r.size[BEAT_SHIFT-1:0];
  assign size_hi  = cmd_r.size[axw_pkg::XFER_W-1:BEAT_SHIFT];

  always_comb begin
    // Partial beat rounds up so whole beats need the minus one
    beats_m1 = (size_rem != '0) ? size_hi : size_hi - 1'b1;
    // Lanes below the remainder are live
    for (int i = 0; i < axw_pkg::BEAT_BYTES; i++) begin
      strb[i] = (size_rem == '0) || (i < size_rem);
    end
  end

  //////////////////////////////
  // Stage 2 plan register
  //////////////////////////////
  always_ff @(posedge aclk) begin
    plan_load <= start_d1;
    if (start_d1) begin
      plan.base      <= cmd_r.addr & ~ADDR_MASK;
      // Upper bits count full bursts and lower bits give the tail
      plan.txn_m1    <= beats_m1[axw_pkg::LEN_W +: axw_pkg::TXN_W];
      plan.last_len  <= beats_m1[0 +: axw_pkg::LEN_W];
      plan.last_strb <= strb;
    end
  end

endmodule

`default_nettype wire

//--- axw_data_channel.sv
// W channel gating, beat and burst counters, WLAST, WSTRB and first-beat pulse
`timescale 1ns/1ps
`default_nettype none

module axw_data_channel (
  input  wire                          aclk,
  input  wire                          areset,
  input  wire axw_pkg::plan_t          plan,
  input  wire                          plan_load,
  input  wire                          s_tvalid,
  input  wire [axw_pkg::DATA_W-1:0]    s_tdata,
  input  wire                          m_wready,
  output logic                         s_tready,
  output logic                         m_wvalid,
  output axw_pkg::w_beat_t             m_w,
  output logic                         burst_first
);

  typedef logic [axw_pkg::LEN_W-1:0] beat_cnt_t;
  typedef logic [axw_pkg::TXN_W-1:0] txn_cnt_t;

  logic     running;
  logic     first;
  logic     shown;
  logic     w_fire;
  logic     beat_load;
  logic     beat_zero;
  logic     burst_zero;
  logic     final_beat;
  txn_cnt_t bursts_left;

  //////////////////////////////
  // Stream to W pass-through
  //////////////////////////////
  // Nothing moves until the plan is known
  assign m_wvalid = s_tvalid & running;
  assign s_tready = m_wready & running;
  assign w_fire   = m_wvalid & m_wready;

  assign final_beat = beat_zero & burst_zero;

  always_comb begin
    m_w.data = s_tdata;
    m_w.last = beat_zero;
    // Partial lanes only on the very last beat
    m_w.strb = final_beat ? plan.last_strb : '1;
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      running <= 1'b0;
    end else if (plan_load) begin
      running <= 1'b1;
    end else if (w_fire && final_beat) begin
      running <= 1'b0;
    end
  end

  //////////////////////////////
  // Beat and burst counters
  //////////////////////////////
  // Tail length goes in at start for one burst or after the next-to-last WLAST
  assign beat_load = (plan_load && (plan.txn_m1 == '0)) ||
                     (w_fire && beat_zero && (bursts_left == txn_cnt_t'(1)));

  // Wraps from zero back to 255 after every WLAST
  axw_counter #(
    .count_t (beat_cnt_t),
    .INIT    ('1)
  ) u_beat_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (beat_load),
    .load_value (plan.last_len),
    .incr       (1'b0),
    .decr       (w_fire),
    .count      (),
    .is_zero    (beat_zero)
  );

  axw_counter #(
    .count_t (txn_cnt_t),
    .INIT    ('0)
  ) u_burst_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (plan_load),
    .load_value (plan.txn_m1),
    .incr       (1'b0),
    .decr       (w_fire & beat_zero),
    .count      (bursts_left),
    .is_zero    (burst_zero)
  );

  //////////////////////////////
  // First beat detection
  //////////////////////////////
  // Next beat opens a burst after each WLAST
  always_ff @(posedge aclk) begin
    if (areset) begin
      first <= 1'b1;
      shown <= 1'b0;
    end else begin
      if (w_fire) begin
        first <= beat_zero;
      end
      // Remember a first beat that is waiting on WREADY
      if (w_fire) begin
        shown <= 1'b0;
      end else if (m_wvalid && first) begin
        shown <= 1'b1;
      end
    end
  end

  assign burst_first = m_wvalid & first & ~shown;

endmodule

`default_nettype wire

//--- axw_addr_channel.sv
// AW issue after first data of each burst, address stepping and AWLEN select
`timescale 1ns/1ps
`default_nettype none

module axw_addr_channel (
  input  wire                 aclk,
  input  wire                 areset,
  input  wire axw_pkg::plan_t plan,
  input  wire                 plan_load,
  input  wire                 burst_first,
  input  wire                 aw_stall,
  input  wire                 m_awready,
  output logic                m_awvalid,
  output axw_pkg::aw_beat_t   m_aw,
  output logic                aw_fire
);

  // One extra bit so every burst of a command can be pending
  typedef logic [axw_pkg::TXN_W:0]   pend_cnt_t;
  typedef logic [axw_pkg::TXN_W-1:0] txn_cnt_t;

  logic                        idle;
  logic                        aw_last_burst;
  logic [axw_pkg::ADDR_W-1:0]  addr_r;

  assign aw_fire = m_awvalid & m_awready;

  //////////////////////////////
  // Pending first beats
  //////////////////////////////
  // Bursts whose data has shown up but whose address has not gone out
  axw_counter #(
    .count_t (pend_cnt_t),
    .INIT    ('0)
  ) u_pend_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .load_value ('0),
    .incr       (burst_first),
    .decr       (aw_fire),
    .count      (),
    .is_zero    (idle)
  );

  axw_counter #(
    .count_t (txn_cnt_t),
    .INIT    ('0)
  ) u_burst_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (plan_load),
    .load_value (plan.txn_m1),
    .incr       (1'b0),
    .decr       (aw_fire),
    .count      (),
    .is_zero    (aw_last_burst)
  );

  //////////////////////////////
  // AWVALID and payload
  //////////////////////////////
  // Stall only blocks the rise and a raised valid waits for AWREADY
  always_ff @(posedge aclk) begin
    if (areset) begin
      m_awvalid <= 1'b0;
    end else if (!idle && !m_awvalid && !aw_stall) begin
      m_awvalid <= 1'b1;
    end else if (m_awready) begin
      m_awvalid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (plan_load) begin
      addr_r <= plan.base;
    end else if (aw_fire) begin
      addr_r <= addr_r + axw_pkg::ADDR_W'(axw_pkg::BURST_BYTES);
    end
  end

  always_comb begin
    m_aw.addr = addr_r;
    // Full bursts except the tail
    m_aw.len  = aw_last_burst ? plan.last_len
                              : axw_pkg::LEN_W'(axw_pkg::BURST_BEATS - 1);
  end

endmodule

`default_nettype wire

//--- axw_resp_tracker.sv
// B acceptance, outstanding vacancy count with AW stall, and done pulse
`timescale 1ns/1ps
`default_nettype none

module axw_resp_tracker #(
  parameter int MAX_OUTSTANDING = 4
) (
  input  wire                 aclk,
  input  wire                 areset,
  input  wire axw_pkg::plan_t plan,
  input  wire                 plan_load,
  input  wire                 aw_fire,
  input  wire                 m_bvalid,
  output logic                m_bready,
  output logic                aw_stall,
  output logic                ctrl_done
);

  localparam int VAC_W = $clog2(MAX_OUTSTANDING + 1);

  typedef logic [VAC_W-1:0]          vac_cnt_t;
  typedef logic [axw_pkg::TXN_W-1:0] txn_cnt_t;

  logic b_fire;
  logic b_last;

  // Responses are never back-pressured
  assign m_bready = 1'b1;
  assign b_fire   = m_bvalid & m_bready;

  //////////////////////////////
  // Response count and done
  //////////////////////////////
  axw_counter #(
    .count_t (txn_cnt_t),
    .INIT    ('0)
  ) u_resp_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (plan_load),
    .load_value (plan.txn_m1),
    .incr       (1'b0),
    .decr       (b_fire),
    .count      (),
    .is_zero    (b_last)
  );

  always_ff @(posedge aclk) begin
    if (areset) begin
      ctrl_done <= 1'b0;
    end else begin
      ctrl_done <= b_fire & b_last;
    end
  end

  //////////////////////////////
  // Outstanding vacancy
  //////////////////////////////
  // AW takes a slot and B gives it back
  axw_counter #(
    .count_t (vac_cnt_t),
    .INIT    (vac_cnt_t'(MAX_OUTSTANDING))
  ) u_vac_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .load_value ('0),
    .incr       (b_fire),
    .decr       (aw_fire),
    .count      (),
    .is_zero    (aw_stall)
  );

endmodule

`default_nettype wire

//--- axw_master_top.sv
// Top level of the stream-fed AXI4 write master with decode, channels and tracker
`timescale 1ns/1ps
`default_nettype none

module axw_master_top #(
  parameter int MAX_OUTSTANDING = 4
) (
  input  wire                        aclk,
  input  wire                        areset,
  // Command
  input  wire                        ctrl_start,
  input  wire axw_pkg::cmd_t         ctrl_cmd,
  output logic                       ctrl_done,
  // Stream in
  input  wire                        s_tvalid,
  output logic                       s_tready,
  input  wire [axw_pkg::DATA_W-1:0]  s_tdata,
  // AXI write address
  output logic                       m_awvalid,
  input  wire                        m_awready,
  output axw_pkg::aw_beat_t          m_aw,
  // AXI write data
  output logic                       m_wvalid,
  input  wire                        m_wready,
  output axw_pkg::w_beat_t           m_w,
  // AXI write response
  input  wire                        m_bvalid,
  output logic                       m_bready
);

  axw_pkg::plan_t plan;
  logic           plan_load;
  logic           burst_first;
  logic           aw_fire;
  logic           aw_stall;

  //////////////////////////////
  // Command decode
  //////////////////////////////
  axw_cmd_decode u_decode (
    .aclk       (aclk),
    .ctrl_start (ctrl_start),
    .ctrl_cmd   (ctrl_cmd),
    .plan       (plan),
    .plan_load  (plan_load)
  );

  //////////////////////////////
  // Channel engines
  //////////////////////////////
  axw_data_channel u_data (
    .aclk        (aclk),
    .areset      (areset),
    .plan        (plan),
    .plan_load   (plan_load),
    .s_tvalid    (s_tvalid),
    .s_tdata     (s_tdata),
    .m_wready    (m_wready),
    .s_tready    (s_tready),
    .m_wvalid    (m_wvalid),
    .m_w         (m_w),
    .burst_first (burst_first)
  );

  axw_addr_channel u_addr (
    .aclk        (aclk),
    .areset      (areset),
    .plan        (plan),
    .plan_load   (plan_load),
    .burst_first (burst_first),
    .aw_stall    (aw_stall),
    .m_awready   (m_awready),
    .m_awvalid   (m_awvalid),
    .m_aw        (m_aw),
    .aw_fire     (aw_fire)
  );

  // Response side limits AW through aw_stall
  axw_resp_tracker #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_resp (
    .aclk      (aclk),
    .areset    (areset),
    .plan      (plan),
    .plan_load (plan_load),
    .aw_fire   (aw_fire),
    .m_bvalid  (m_bvalid),
    .m_bready  (m_bready),
    .aw_stall  (aw_stall),
    .ctrl_done (ctrl_done)
  );

endmodule

`default_nettype wire

//--- axw_props.sv
// AXI handshake stability and outstanding-limit assertions bound into the master top
`timescale 1ns/1ps
`default_nettype none

module axw_props #(
  parameter int MAX_OUTSTANDING = 4
) (
  input wire                    aclk,
  input wire                    areset,
  input wire                    m_awvalid,
  input wire                    m_awready,
  input wire axw_pkg::aw_beat_t m_aw,
  input wire                    m_wvalid,
  input wire                    m_wready,
  input wire axw_pkg::w_beat_t  m_w,
  input wire                    m_bvalid,
  input wire                    m_bready
);

  // Failed assertions so far
  int fail_count = 0;
  // AW handshakes not yet answered by B
  int in_flight;

  always_ff @(posedge aclk) begin
    if (areset) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(m_awvalid && m_awready) - int'(m_bvalid && m_bready);
    end
  end

  //////////////////////////////
  // Channel stability
  //////////////////////////////
  a_aw_hold : assert property (@(posedge aclk) disable iff (areset)
    (m_awvalid && !m_awready) |=> (m_awvalid && $stable(m_aw)))
    else begin
      $error("AW valid or payload changed before AWREADY");
      fail_count++;
    end

  a_w_hold : assert property (@(posedge aclk) disable iff (areset)
    (m_wvalid && !m_wready) |=> (m_wvalid && $stable(m_w)))
    else begin
      $error("W valid or payload changed before WREADY");
      fail_count++;
    end

  //////////////////////////////
  // Outstanding limit
  //////////////////////////////
  a_in_flight : assert property (@(posedge aclk) disable iff (areset)
    in_flight <= MAX_OUTSTANDING)
    else begin
      $error("more AW bursts in flight than MAX_OUTSTANDING");
      fail_count++;
    end

endmodule

bind axw_master_top axw_props #(
  .MAX_OUTSTANDING (MAX_OUTSTANDING)
) u_props (
  .aclk      (aclk),
  .areset    (areset),
  .m_awvalid (m_awvalid),
  .m_awready (m_awready),
  .m_aw      (m_aw),
  .m_wvalid  (m_wvalid),
  .m_wready  (m_wready),
  .m_w       (m_w),
  .m_bvalid  (m_bvalid),
  .m_bready  (m_bready)
);

`default_nettype wire

//--- axw_checker.sv
// Scoreboard that rebuilds each command's burst plan and compares every AXI handshake
`timescale 1ns/1ps
`default_nettype none

module axw_checker #(
  parameter int          MAX_OUTSTANDING = 4,
  parameter logic [31:0] DATA_BASE       = '0
) (
  input  wire                    aclk,
  input  wire                    areset,
  input  wire                    ctrl_start,
  input  wire axw_pkg::cmd_t     ctrl_cmd,
  input  wire                    ctrl_done,
  input  wire                    s_tready,
  input  wire                    m_awvalid,
  input  wire                    m_awready,
  input  wire axw_pkg::aw_beat_t m_aw,
  input  wire                    m_wvalid,
  input  wire                    m_wready,
  input  wire axw_pkg::w_beat_t  m_w,
  input  wire                    m_bvalid,
  input  wire                    m_bready,
  output int                     check_count,
  output int                     error_count,
  output int                     done_count
);

  int          checks = 0;
  int          errors = 0;
  int          dones = 0;
  int          cmd_idx = -1;
  // Expected plan of the running command
  int          exp_beats = 0;
  int          exp_bursts = 0;
  int          exp_last_len = 0;
  logic [31:0] exp_base = '0;
  logic [3:0]  exp_strb = 4'hf;
  logic [31:0] exp_data = DATA_BASE;
  // Handshakes seen so far in the command
  int          w_cnt = 0;
  int          aw_cnt = 0;
  int          b_cnt = 0;
  logic        done_due = 1'b0;
  logic        rst_d = 1'b0;

  assign check_count = checks;
  assign error_count = errors;
  assign done_count  = dones;

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("error %s cmd %0d: expected %h actual %h", name, cmd_idx, expected, actual);
    end
  endtask

  task automatic fault(input string what);
    errors++;
    $display("cmd %0d: %s", cmd_idx, what);
  endtask

  //////////////////////////////
  // Per-edge comparison
  //////////////////////////////
  always @(posedge aclk) begin : scoreboard
    logic aw_fire;
    logic w_fire;
    logic b_fire;
    int   rem;
    aw_fire = m_awvalid && m_awready;
    w_fire  = m_wvalid && m_wready;
    b_fire  = m_bvalid && m_bready;
    // Outputs during reset and on the first edge after it
    if (rst_d) begin
      compare("reset_awvalid", 32'd0, 32'(m_awvalid));
      compare("reset_wvalid", 32'd0, 32'(m_wvalid));
      compare("reset_tready", 32'd0, 32'(s_tready));
      compare("reset_done", 32'd0, 32'(ctrl_done));
    end
    rst_d = areset;
    if (!areset) begin
      // Done must follow the final B by exactly one edge
      compare("done", 32'(done_due), 32'(ctrl_done));
      if (ctrl_done === 1'b1) begin
        dones++;
        compare("beat_count", exp_beats, w_cnt);
        compare("burst_count", exp_bursts, aw_cnt);
      end
      done_due = 1'b0;

      // Responses are taken as soon as they are offered
      if (m_bvalid === 1'b1) begin
        compare("b_ready", 32'd1, 32'(m_bready));
      end

      if (aw_fire) begin
        if (aw_cnt >= exp_bursts) begin
          fault("AW handshake after the last burst of the command");
        end else begin
          compare("aw_addr", exp_base + 32'(aw_cnt * 1024), m_aw.addr);
          compare("aw_len", (aw_cnt == exp_bursts - 1) ? exp_last_len : 255, 32'(m_aw.len));
        end
        aw_cnt++;
      end

      if (w_fire) begin
        if (w_cnt >= exp_beats) begin
          fault("W beat after the end of the command");
        end else begin
          compare("w_data", exp_data, m_w.data);
          compare("w_last", 32'((w_cnt % 256 == 255) || (w_cnt == exp_beats - 1)),
                  32'(m_w.last));
          compare("w_strb", (w_cnt == exp_beats - 1) ? 32'(exp_strb) : 32'hf, 32'(m_w.strb));
        end
        exp_data++;
        w_cnt++;
      end

      if (b_fire) begin
        if (b_cnt == exp_bursts - 1) begin
          done_due = 1'b1;
        end
        b_cnt++;
      end

      if (aw_cnt - b_cnt > MAX_OUTSTANDING) begin
        fault("AW ran more bursts ahead of B than the outstanding limit");
      end

      // New command resets the model
      if (ctrl_start) begin
        cmd_idx++;
        exp_beats    = (int'(ctrl_cmd.size) + 3) / 4;
        exp_bursts   = (exp_beats + 255) / 256;
        exp_last_len = exp_beats - (exp_bursts - 1) * 256 - 1;
        exp_base     = ctrl_cmd.addr & ~32'h3ff;
        rem          = int'(ctrl_cmd.size) % 4;
        exp_strb     = (rem == 0) ? 4'hf : 4'((1 << rem) - 1);
        w_cnt        = 0;
        aw_cnt       = 0;
        b_cnt        = 0;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_axw_master.sv
// Testbench top with clock, reset, random commands and stream, AXI slave model and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_axw_master;

  localparam int          NUM_CMDS  = 22;
  // Low enough that slow B responses hold back the next AW
  localparam int          MAX_OUT   = 1;
  localparam logic [31:0] DATA_BASE = 32'h0a00_0000;

  logic              aclk;
  logic              areset;
  logic              ctrl_start;
  axw_pkg::cmd_t     ctrl_cmd;
  logic              ctrl_done;
  logic              s_tvalid;
  logic              s_tready;
  logic [31:0]       s_tdata;
  logic              m_awvalid;
  logic              m_awready;
  axw_pkg::aw_beat_t m_aw;
  logic              m_wvalid;
  logic              m_wready;
  axw_pkg::w_beat_t  m_w;
  logic              m_bvalid;
  logic              m_bready;

  integer        seed;
  axw_pkg::cmd_t cmds [NUM_CMDS];
  int            timeout_limit = 0;
  int            cycle = 0;
  // Stream source state
  int            stream_left = 0;
  logic [31:0]   stream_data = DATA_BASE;
  logic          stream_moved = 1'b0;
  // Slave side bookkeeping
  int            aw_accepted = 0;
  int            b_sent = 0;
  int            b_due [$];
  int            check_count;
  int            error_count;
  int            done_count;

  axw_master_top #(
    .MAX_OUTSTANDING (MAX_OUT)
  ) dut0 (
    .aclk (aclk), .areset (areset),
    .ctrl_start (ctrl_start), .ctrl_cmd (ctrl_cmd), .ctrl_done (ctrl_done),
    .s_tvalid (s_tvalid), .s_tready (s_tready), .s_tdata (s_tdata),
    .m_awvalid (m_awvalid), .m_awready (m_awready), .m_aw (m_aw),
    .m_wvalid (m_wvalid), .m_wready (m_wready), .m_w (m_w),
    .m_bvalid (m_bvalid), .m_bready (m_bready)
  );

  axw_checker #(
    .MAX_OUTSTANDING (MAX_OUT),
    .DATA_BASE       (DATA_BASE)
  ) u_checker (
    .aclk (aclk), .areset (areset),
    .ctrl_start (ctrl_start), .ctrl_cmd (ctrl_cmd), .ctrl_done (ctrl_done),
    .s_tready (s_tready),
    .m_awvalid (m_awvalid), .m_awready (m_awready), .m_aw (m_aw),
    .m_wvalid (m_wvalid), .m_wready (m_wready), .m_w (m_w),
    .m_bvalid (m_bvalid), .m_bready (m_bready),
    .check_count (check_count), .error_count (error_count), .done_count (done_count)
  );

  function automatic int pick_in_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  function automatic int beats_for(input logic [15:0] size);
    return (int'(size) + 3) / 4;
  endfunction

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  //////////////////////////////
  // Stream and slave model
  //////////////////////////////
  // Handshake bookkeeping at the rising edge
  always @(posedge aclk) begin
    cycle++;
    if (ctrl_start) begin
      stream_left = beats_for(ctrl_cmd.size);
    end
    stream_moved = s_tvalid && s_tready;
    if (stream_moved) begin
      stream_left--;
      stream_data++;
    end
    if (m_awvalid && m_awready) begin
      aw_accepted++;
    end
    // One B per WLAST after a random delay
    if (m_wvalid && m_wready && m_w.last) begin
      b_due.push_back(cycle + pick_in_range(1, 30));
    end
    if (m_bvalid && m_bready) begin
      b_sent++;
      void'(b_due.pop_front());
    end
  end

  // Inputs change on the falling edge
  always @(negedge aclk) begin
    if (!areset) begin
      // A raised TVALID holds until its beat is taken
      if (!s_tvalid || stream_moved) begin
        s_tvalid = (stream_left > 0) && (pick_in_range(0, 3) != 0);
      end
      s_tdata   = stream_data;
      m_awready = (pick_in_range(0, 1) == 1);
      m_wready  = (pick_in_range(0, 3) != 0);
      // B never overtakes its AW
      m_bvalid  = (b_due.size() > 0) && (b_due[0] <= cycle) && (b_sent < aw_accepted);
    end
  end

  //////////////////////////////
  // Command sequence
  //////////////////////////////
  task automatic run_command(input int idx);
    @(negedge aclk);
    ctrl_cmd   = cmds[idx];
    ctrl_start = 1'b1;
    @(negedge aclk);
    ctrl_start = 1'b0;
    do begin
      @(posedge aclk);
    end while (ctrl_done !== 1'b1);
  endtask

  initial begin : main
    int i;
    int total_beats;
    int run_errors;
    int prop_fails;
    seed       = 32'h51c5;
    areset     = 1'b1;
    ctrl_start = 1'b0;
    ctrl_cmd   = '0;
    s_tvalid   = 1'b0;
    s_tdata    = '0;
    m_awready  = 1'b0;
    m_wready   = 1'b0;
    m_bvalid   = 1'b0;
    run_errors = 0;
    // Exact one-burst and one-beat-over sizes first
    cmds[0].addr = $random(seed);
    cmds[0].size = 16'd1024;
    cmds[1].addr = $random(seed);
    cmds[1].size = 16'd1025;
    for (i = 2; i < NUM_CMDS; i++) begin
      cmds[i].addr = $random(seed);
      cmds[i].size = 16'(pick_in_range(1, 3000));
    end
    total_beats = 0;
    for (i = 0; i < NUM_CMDS; i++) begin
      total_beats += beats_for(cmds[i].size);
    end
    timeout_limit = 20 * total_beats + 300 * NUM_CMDS;

    repeat (16) @(posedge aclk);
    @(negedge aclk);
    areset = 1'b0;
    for (i = 0; i < NUM_CMDS; i++) begin
      run_command(i);
    end
    // Quiet tail catches stray handshakes or done pulses
    repeat (40) @(posedge aclk);

    if (done_count != NUM_CMDS) begin
      $display("done pulsed %0d times for %0d commands", done_count, NUM_CMDS);
      run_errors++;
    end
    prop_fails = dut0.u_props.fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d",
             check_count, error_count + run_errors, prop_fails);
    if (error_count + run_errors + prop_fails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Cycle budget from the total beat count
  initial begin : watchdog
    wait (timeout_limit > 0);
    wait (cycle >= timeout_limit);
    $display("timeout: the run did not finish within %0d cycles", timeout_limit);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
axw_pkg.sv
axw_counter.sv
axw_cmd_decode.sv
axw_data_channel.sv
axw_addr_channel.sv
axw_resp_tracker.sv
axw_master_top.sv
axw_props.sv
axw_checker.sv
tb_axw_master.sv

//--- Bender.yml
package:
  name: axw_master

sources:
  - axw_pkg.sv
  - axw_counter.sv
  - axw_cmd_decode.sv
  - axw_data_channel.sv
  - axw_addr_channel.sv
  - axw_resp_tracker.sv
  - axw_master_top.sv
  - target: test
    files:
      - axw_props.sv
      - axw_checker.sv
      - tb_axw_master.sv
